//--- hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define XLEN        64
`define INST_W      32
`define ADDR_W      64
`define REG_IDX_W   5

`define PC_START    64'h0

// major opcodes
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011
`define OP_LUI      7'b0110111
`define OP_JAL      7'b1101111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011

// funct3 / funct7 values
`define F3_ADD      3'b000
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_WORD     3'b010
`define F3_DOUBLE   3'b011
`define F7_SUB      7'b0100000

// bus size codes
`define SIZE_WORD   2'd2
`define SIZE_DOUBLE 2'd3

`endif

//--- hw/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]      xlen_t;
    typedef logic [`ADDR_W-1:0]    addr_t;
    typedef logic [`INST_W-1:0]    inst_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // bus access size code
    typedef logic [1:0] size_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        // lui result is the immediate itself
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic {
        FETCH,
        EXEC
    } fetch_state_t;

endpackage

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module fetch_unit (
    input  wire                  inst_selfdefine,
    input  wire                  reset,
    input  wire                  f_done,
    input  wire cpu_pkg::xlen_t  f_rdata,
    input  wire cpu_pkg::addr_t  next_pc,
    input  wire                  mem_op,
    input  wire                  lsu_done,
    output logic                 f_req,
    output cpu_pkg::addr_t       f_addr,
    output cpu_pkg::addr_t       pc,
    output cpu_pkg::inst_t       inst,
    output logic                 retire
);

    cpu_pkg::fetch_state_t state;

    assign f_req  = (state == cpu_pkg::FETCH);
    assign f_addr = pc;

    // memory ops wait for the lsu, everything else retires at once
    assign retire = (state == cpu_pkg::EXEC) && (!mem_op || lsu_done);

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state <= cpu_pkg::FETCH;
            pc    <= `PC_START;
            inst  <= '0;
        end else begin
            case (state)
                cpu_pkg::FETCH: begin
                    if (f_done) begin
                        inst  <= f_rdata[`INST_W-1:0];
                        state <= cpu_pkg::EXEC;
                    end
                end
                cpu_pkg::EXEC: begin
                    if (retire) begin
                        pc    <= next_pc;
                        // zero word decodes as nothing while fetching
                        inst  <= '0;
                        state <= cpu_pkg::FETCH;
                    end
                end
                default: state <= cpu_pkg::FETCH;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module decoder (
    input  wire cpu_pkg::inst_t  inst,
    output cpu_pkg::reg_idx_t    rs1_idx,
    output cpu_pkg::reg_idx_t    rs2_idx,
    output cpu_pkg::reg_idx_t    rd_idx,
    output logic                 rd_en,
    output cpu_pkg::xlen_t       imm,
    output cpu_pkg::alu_op_t     alu_op,
    output logic                 alu_src_imm,
    output logic                 is_jal,
    output logic                 is_branch,
    output logic                 branch_ne,
    output logic                 mem_op,
    output logic                 mem_write,
    output cpu_pkg::size_t       mem_size
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic           has_rd;
    cpu_pkg::xlen_t imm_i;
    cpu_pkg::xlen_t imm_s;
    cpu_pkg::xlen_t imm_b;
    cpu_pkg::xlen_t imm_u;
    cpu_pkg::xlen_t imm_j;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];
    assign rd_idx  = inst[11:7];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // x0 never gets written
    assign rd_en = has_rd && (rd_idx != '0);

    always_comb begin
        has_rd      = 1'b0;
        imm         = imm_i;
        alu_op      = cpu_pkg::ALU_ADD;
        alu_src_imm = 1'b0;
        is_jal      = 1'b0;
        is_branch   = 1'b0;
        branch_ne   = 1'b0;
        mem_op      = 1'b0;
        mem_write   = 1'b0;
        mem_size    = `SIZE_DOUBLE;
        case (opcode)
            `OP_IMM, `OP_REG: begin
                alu_src_imm = (opcode == `OP_IMM);
                has_rd      = 1'b1;
                case (funct3)
                    `F3_ADD: begin
                        if (opcode == `OP_REG && funct7 == `F7_SUB) begin
                            alu_op = cpu_pkg::ALU_SUB;
                        end
                    end
                    `F3_XOR: alu_op = cpu_pkg::ALU_XOR;
                    `F3_OR:  alu_op = cpu_pkg::ALU_OR;
                    `F3_AND: alu_op = cpu_pkg::ALU_AND;
                    // shifts and slt are not supported
                    default: has_rd = 1'b0;
                endcase
            end
            `OP_LUI: begin
                imm         = imm_u;
                alu_op      = cpu_pkg::ALU_PASS_B;
                alu_src_imm = 1'b1;
                has_rd      = 1'b1;
            end
            `OP_JAL: begin
                imm    = imm_j;
                is_jal = 1'b1;
                has_rd = 1'b1;
            end
            `OP_BRANCH: begin
                imm       = imm_b;
                is_branch = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
                branch_ne = (funct3 == `F3_BNE);
            end
            `OP_LOAD, `OP_STORE: begin
                imm         = (opcode == `OP_STORE) ? imm_s : imm_i;
                alu_src_imm = 1'b1;
                mem_size    = (funct3 == `F3_WORD) ? `SIZE_WORD : `SIZE_DOUBLE;
                // only lw/ld/sw/sd
                if (funct3 == `F3_WORD || funct3 == `F3_DOUBLE) begin
                    mem_op    = 1'b1;
                    mem_write = (opcode == `OP_STORE);
                    has_rd    = (opcode == `OP_LOAD);
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire cpu_pkg::addr_t    pc,
    input  wire cpu_pkg::xlen_t    rs1_data,
    input  wire cpu_pkg::xlen_t    rs2_data,
    input  wire cpu_pkg::xlen_t    imm,
    input  wire cpu_pkg::alu_op_t  alu_op,
    input  wire                    alu_src_imm,
    input  wire                    is_jal,
    input  wire                    is_branch,
    input  wire                    branch_ne,
    input  wire                    mem_op,
    input  wire cpu_pkg::xlen_t    load_data,
    output cpu_pkg::xlen_t         alu_res,
    output cpu_pkg::addr_t         next_pc,
    output cpu_pkg::xlen_t         rd_data
);

    cpu_pkg::xlen_t op_b;
    cpu_pkg::addr_t pc_plus4;
    logic           taken;

    assign op_b     = alu_src_imm ? imm : rs2_data;
    assign pc_plus4 = pc + 64'd4;

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_SUB:    alu_res = rs1_data - op_b;
            cpu_pkg::ALU_AND:    alu_res = rs1_data & op_b;
            cpu_pkg::ALU_OR:     alu_res = rs1_data | op_b;
            cpu_pkg::ALU_XOR:    alu_res = rs1_data ^ op_b;
            cpu_pkg::ALU_PASS_B: alu_res = op_b;
            default:             alu_res = rs1_data + op_b;
        endcase
    end

    // beq on equal, bne on not equal
    assign taken   = is_branch && ((rs1_data == rs2_data) ^ branch_ne);
    assign next_pc = (taken || is_jal) ? pc + imm : pc_plus4;

    assign rd_data = is_jal ? pc_plus4 : (mem_op ? load_data : alu_res);

endmodule

`default_nettype wire

//--- hw/lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module lsu (
    input  wire                  inst_selfdefine,
    input  wire                  reset,
    input  wire                  mem_op,
    input  wire                  mem_write,
    input  wire cpu_pkg::size_t  mem_size,
    input  wire cpu_pkg::xlen_t  alu_res,
    input  wire cpu_pkg::xlen_t  rs2_data,
    input  wire                  d_done,
    input  wire cpu_pkg::xlen_t  d_rdata,
    output logic                 d_req,
    output logic                 d_write,
    output cpu_pkg::addr_t       d_addr,
    output cpu_pkg::size_t       d_size,
    output cpu_pkg::xlen_t       d_wdata,
    output logic                 lsu_done,
    output cpu_pkg::xlen_t       load_data
);

    // request accepted and not yet answered
    logic busy;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (d_done) begin
            busy <= 1'b0;
        end else if (d_req) begin
            busy <= 1'b1;
        end
    end

    // dropped in the retire cycle so no second access starts
    assign d_req    = mem_op && !d_done;
    assign lsu_done = d_done && busy;

    assign d_write  = mem_write;
    assign d_addr   = alu_res;
    assign d_size   = mem_size;
    assign d_wdata  = rs2_data;

    // lw sign-extends the low word
    assign load_data = (mem_size == `SIZE_WORD) ?
                       {{32{d_rdata[31]}}, d_rdata[31:0]} : d_rdata;

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module bus_arbiter (
    input  wire                  inst_selfdefine,
    input  wire                  reset,
    input  wire                  f_req,
    input  wire cpu_pkg::addr_t  f_addr,
    input  wire                  d_req,
    input  wire                  d_write,
    input  wire cpu_pkg::addr_t  d_addr,
    input  wire cpu_pkg::size_t  d_size,
    input  wire cpu_pkg::xlen_t  d_wdata,
    input  wire                  mem_ready,
    input  wire cpu_pkg::xlen_t  mem_rdata,
    output logic                 f_done,
    output cpu_pkg::xlen_t       f_rdata,
    output logic                 d_done,
    output cpu_pkg::xlen_t       d_rdata,
    output logic                 mem_valid,
    output logic                 mem_write,
    output cpu_pkg::addr_t       mem_addr,
    output cpu_pkg::size_t       mem_size,
    output cpu_pkg::xlen_t       mem_wdata
);

    // both owner bits low means idle
    logic own_fetch;
    logic own_data;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            own_fetch <= 1'b0;
            own_data  <= 1'b0;
        end else if (!own_fetch && !own_data) begin
            // data side has priority
            own_data  <= d_req;
            own_fetch <= f_req && !d_req;
        end else if (mem_ready) begin
            own_fetch <= 1'b0;
            own_data  <= 1'b0;
        end
    end

    assign mem_valid = own_fetch || own_data;
    assign mem_write = own_data && d_write;
    assign mem_addr  = own_data ? d_addr : f_addr;
    assign mem_size  = own_data ? d_size : `SIZE_WORD;
    assign mem_wdata = own_data ? d_wdata : '0;

    assign f_done  = own_fetch && mem_ready;
    assign d_done  = own_data && mem_ready;
    assign f_rdata = mem_rdata;
    assign d_rdata = mem_rdata;

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                     inst_selfdefine,
    input  wire                     reset,
    input  wire cpu_pkg::reg_idx_t  rs1_idx,
    input  wire cpu_pkg::reg_idx_t  rs2_idx,
    input  wire cpu_pkg::reg_idx_t  rd_idx,
    input  wire                     we,
    input  wire cpu_pkg::xlen_t     rd_data,
    output cpu_pkg::xlen_t          rs1_data,
    output cpu_pkg::xlen_t          rs2_data
);

    cpu_pkg::xlen_t regs [32];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_idx != '0) begin
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

//--- hw/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  wire                  inst_selfdefine,
    input  wire                  reset,
    input  wire                  mem_ready,
    input  wire cpu_pkg::xlen_t  mem_rdata,
    output logic                 mem_valid,
    output logic                 mem_write,
    output cpu_pkg::addr_t       mem_addr,
    output cpu_pkg::size_t       mem_size,
    output cpu_pkg::xlen_t       mem_wdata
);

    // fetch side
    logic                f_req;
    cpu_pkg::addr_t      f_addr;
    logic                f_done;
    cpu_pkg::xlen_t      f_rdata;
    cpu_pkg::addr_t      pc;
    cpu_pkg::inst_t      inst;
    logic                retire;
    cpu_pkg::addr_t      next_pc;

    // decode
    cpu_pkg::reg_idx_t   rs1_idx;
    cpu_pkg::reg_idx_t   rs2_idx;
    cpu_pkg::reg_idx_t   rd_idx;
    logic                rd_en;
    cpu_pkg::xlen_t      imm;
    cpu_pkg::alu_op_t    alu_op;
    logic                alu_src_imm;
    logic                is_jal;
    logic                is_branch;
    logic                branch_ne;
    logic                mem_op;
    logic                ls_write;
    cpu_pkg::size_t      ls_size;

    // execute and registers
    cpu_pkg::xlen_t      rs1_data;
    cpu_pkg::xlen_t      rs2_data;
    cpu_pkg::xlen_t      alu_res;
    cpu_pkg::xlen_t      rd_data;

    // data side
    logic                d_req;
    logic                d_write;
    cpu_pkg::addr_t      d_addr;
    cpu_pkg::size_t      d_size;
    cpu_pkg::xlen_t      d_wdata;
    logic                d_done;
    cpu_pkg::xlen_t      d_rdata;
    logic                lsu_done;
    cpu_pkg::xlen_t      load_data;

    fetch_unit fetch_unit0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .f_done          (f_done),
        .f_rdata         (f_rdata),
        .next_pc         (next_pc),
        .mem_op          (mem_op),
        .lsu_done        (lsu_done),
        .f_req           (f_req),
        .f_addr          (f_addr),
        .pc              (pc),
        .inst            (inst),
        .retire          (retire)
    );

    decoder decoder0 (
        .inst        (inst),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rd_idx      (rd_idx),
        .rd_en       (rd_en),
        .imm         (imm),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .is_jal      (is_jal),
        .is_branch   (is_branch),
        .branch_ne   (branch_ne),
        .mem_op      (mem_op),
        .mem_write   (ls_write),
        .mem_size    (ls_size)
    );

    execute_unit execute_unit0 (
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .is_jal      (is_jal),
        .is_branch   (is_branch),
        .branch_ne   (branch_ne),
        .mem_op      (mem_op),
        .load_data   (load_data),
        .alu_res     (alu_res),
        .next_pc     (next_pc),
        .rd_data     (rd_data)
    );

    lsu lsu0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .mem_op          (mem_op),
        .mem_write       (ls_write),
        .mem_size        (ls_size),
        .alu_res         (alu_res),
        .rs2_data        (rs2_data),
        .d_done          (d_done),
        .d_rdata         (d_rdata),
        .d_req           (d_req),
        .d_write         (d_write),
        .d_addr          (d_addr),
        .d_size          (d_size),
        .d_wdata         (d_wdata),
        .lsu_done        (lsu_done),
        .load_data       (load_data)
    );

    // register write lands on the retire edge only
    regfile regfile0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .rs1_idx         (rs1_idx),
        .rs2_idx         (rs2_idx),
        .rd_idx          (rd_idx),
        .we              (rd_en & retire),
        .rd_data         (rd_data),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data)
    );

    bus_arbiter bus_arbiter0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .f_req           (f_req),
        .f_addr          (f_addr),
        .d_req           (d_req),
        .d_write         (d_write),
        .d_addr          (d_addr),
        .d_size          (d_size),
        .d_wdata         (d_wdata),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .f_done          (f_done),
        .f_rdata         (f_rdata),
        .d_done          (d_done),
        .d_rdata         (d_rdata),
        .mem_valid       (mem_valid),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_size        (mem_size),
        .mem_wdata       (mem_wdata)
    );

endmodule

`default_nettype wire

//--- tb/cpu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
    input wire                  inst_selfdefine,
    input wire                  reset,
    input wire                  mem_valid,
    input wire                  mem_ready,
    input wire                  mem_write,
    input wire cpu_pkg::addr_t  mem_addr,
    input wire cpu_pkg::size_t  mem_size,
    input wire cpu_pkg::xlen_t  mem_wdata
);

    // bus idle while reset is held
    assert property (@(posedge inst_selfdefine) (reset && $past(reset)) |-> !mem_valid)
        else $error("mem_valid high during reset");

    // a waiting request keeps every field
    assert property (@(posedge inst_selfdefine) disable iff (reset)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr) && $stable(mem_size)
            && $stable(mem_write) && $stable(mem_wdata)))
        else $error("bus request changed before ready");

    assert property (@(posedge inst_selfdefine) !reset |-> !$isunknown(mem_valid))
        else $error("mem_valid is unknown");

endmodule

bind cpu cpu_properties props0 (
    .inst_selfdefine (inst_selfdefine),
    .reset           (reset),
    .mem_valid       (mem_valid),
    .mem_ready       (mem_ready),
    .mem_write       (mem_write),
    .mem_addr        (mem_addr),
    .mem_size        (mem_size),
    .mem_wdata       (mem_wdata)
);

`default_nettype wire

//--- tb/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module tb_cpu;

    logic                inst_selfdefine;
    logic                reset;
    logic                mem_ready;
    cpu_pkg::xlen_t      mem_rdata;
    logic                mem_valid;
    logic                mem_write;
    cpu_pkg::addr_t      mem_addr;
    cpu_pkg::size_t      mem_size;
    cpu_pkg::xlen_t      mem_wdata;

    // byte wide sparse memory
    logic [7:0]          mem [logic [63:0]];
    cpu_pkg::addr_t      exp_addr [$];
    cpu_pkg::xlen_t      exp_data [$];
    cpu_pkg::size_t      exp_size [$];
    cpu_pkg::addr_t      halt_addr;
    logic                have_halt;
    logic                halted;
    logic                loaded;
    int                  prog_len;
    logic [31:0]         rng_state;
    logic                waiting;
    logic [1:0]          wait_left;

    cpu dut0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_valid       (mem_valid),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_size        (mem_size),
        .mem_wdata       (mem_wdata)
    );

    initial begin
        inst_selfdefine = 1'b0;
        forever #5 inst_selfdefine = ~inst_selfdefine;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_store_addr(input cpu_pkg::addr_t got, input cpu_pkg::addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: store address %h, expected %h",
                               $time, got, exp));
        end
    endtask

    task automatic check_store_data(input cpu_pkg::xlen_t got, input cpu_pkg::xlen_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: store data %h, expected %h",
                               $time, got, exp));
        end
    endtask

    task automatic check_size(input cpu_pkg::size_t got, input cpu_pkg::size_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: store size %0d, expected %0d",
                               $time, got, exp));
        end
    endtask

    function automatic cpu_pkg::xlen_t read_bytes(input cpu_pkg::addr_t a, input int n);
        cpu_pkg::xlen_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (mem.exists(a + 64'(i))) begin
                v[i*8 +: 8] = mem[a + 64'(i)];
            end
        end
        return v;
    endfunction

    task automatic write_bytes(input cpu_pkg::addr_t a, input cpu_pkg::xlen_t v, input int n);
        for (int i = 0; i < n; i++) begin
            mem[a + 64'(i)] = v[i*8 +: 8];
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          r;
        string       line;
        logic [63:0] a;
        logic [63:0] d;
        logic [31:0] w;
        logic [1:0]  s;
        fd = $fopen("tb/cpu_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file tb/cpu_stimulus.txt");
        end
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r > 0 && line.getc(0) == "P") begin
                r = $sscanf(line, "P %h %h", a, w);
                write_bytes(a, {32'h0, w}, 4);
                prog_len++;
                // self loop jal marks the halt
                if (w == 32'h0000006f) begin
                    halt_addr = a;
                    have_halt = 1'b1;
                end
            end else if (r > 0 && line.getc(0) == "E") begin
                r = $sscanf(line, "E %h %h %h", a, d, s);
                exp_addr.push_back(a);
                exp_data.push_back(d);
                exp_size.push_back(s);
            end
        end
        $fclose(fd);
        if (!have_halt) begin
            fail_run("the stimulus program has no halt instruction");
        end
    endtask

    task automatic serve_request();
        int n;
        n = (mem_size == `SIZE_WORD) ? 4 : 8;
        mem_ready = 1'b1;
        if (mem_write) begin
            if (exp_addr.size() == 0) begin
                fail_run($sformatf("store to %h at %0t was not expected", mem_addr, $time));
            end
            check_store_addr(mem_addr, exp_addr.pop_front());
            check_store_data(mem_wdata, exp_data.pop_front());
            check_size(mem_size, exp_size.pop_front());
            write_bytes(mem_addr, mem_wdata, n);
            mem_rdata = '0;
        end else begin
            mem_rdata = read_bytes(mem_addr, n);
            if (mem_addr == halt_addr) begin
                halted = 1'b1;
            end
        end
    endtask

    // memory answers after 0 to 3 wait cycles
    always @(negedge inst_selfdefine) begin
        mem_ready = 1'b0;
        if (!reset && mem_valid && !halted) begin
            if (!waiting) begin
                waiting   = 1'b1;
                rng_state = xorshift(rng_state);
                wait_left = rng_state[1:0];
            end
            if (wait_left == 2'd0) begin
                waiting = 1'b0;
                serve_request();
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    initial begin
        reset     = 1'b1;
        mem_ready = 1'b0;
        mem_rdata = '0;
        halted    = 1'b0;
        have_halt = 1'b0;
        loaded    = 1'b0;
        waiting   = 1'b0;
        wait_left = 2'd0;
        halt_addr = '0;
        prog_len  = 0;
        rng_state = 32'h7ac8;
        load_stimulus();
        loaded = 1'b1;
        repeat (10) @(posedge inst_selfdefine);
        @(negedge inst_selfdefine);
        reset = 1'b0;
        wait (halted);
        if (exp_addr.size() != 0) begin
            fail_run($sformatf("program halted with %0d expected stores missing",
                               exp_addr.size()));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (10 + prog_len * 40) @(posedge inst_selfdefine);
        fail_run("timeout: the program did not reach its halt instruction");
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/execute_unit.sv
hw/lsu.sv
hw/bus_arbiter.sv
hw/regfile.sv
hw/cpu.sv
tb/cpu_properties.sv
tb/tb_cpu.sv

//--- run_sim.sh
#!/bin/sh
# builds the cpu testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_cpu \
    -f flist.f --Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- tb/cpu_stimulus.txt
# P address instruction_word          program memory
# E address store_data size_code      expected stores, in order
P 0 00500093
P 4 ffd00113
P 8 002081b3
P c 20303023
P 10 40208233
P 14 20403423
P 18 0020f2b3
P 1c 0020e333
P 20 0020c3b3
P 24 20503823
P 28 20603c23
P 2c 22703023
P 30 80001437
P 34 7ff40413
P 38 22803423
P 3c 22802823
P 40 23002483
P 44 22903c23
P 48 23003583
P 4c 24b03023
P 50 30003603
P 54 24c03423
P 58 00108463
P 5c 24103823
P 60 00109463
P 64 24203c23
P 68 07b00013
P 6c 26003023
P 70 008006ef
P 74 26103423
P 78 26d03823
P 7c 0000006f
P 300 89abcdef
P 304 01234567
E 200 0000000000000002 3
E 208 0000000000000008 3
E 210 0000000000000005 3
E 218 fffffffffffffffd 3
E 220 fffffffffffffff8 3
E 228 ffffffff800017ff 3
E 230 ffffffff800017ff 2
E 238 ffffffff800017ff 3
E 240 00000000800017ff 3
E 248 0123456789abcdef 3
E 258 fffffffffffffffd 3
E 260 0000000000000000 3
E 270 0000000000000074 3
